//--- bench/vend_tb.sv
`timescale 1ns/1ps

`include "vend_defs.svh"

module vend_tb
    import vend_pkg::*;
();

    // two cycles per press, plus room for the refund payout
    localparam int max_presses = 64;
    localparam int cycle_limit = 2 + 2 * max_presses + 64 * `VEND_PAY_INTERVAL;

    logic                      clk;
    logic                      rst;
    logic [`VEND_BTN_W-1:0]    button_sw_oneshot;
    logic [`VEND_CREDIT_W-1:0] credit;
    logic [1:0]                cursor;
    logic [2:0]                selected_item;
    logic [`VEND_STOCK_W-1:0]  stock_current;
    logic                      admin_mode;
    vend_status_e              status;
    logic                      coin_out;
    logic                      refund_busy;

    int cycles = 0;

    // reference model
    int price [`VEND_NUM_PROD] = '{`VEND_PRICE_1, `VEND_PRICE_2, `VEND_PRICE_3, `VEND_PRICE_4};
    int exp_stock [`VEND_NUM_PROD] = '{`VEND_INIT_STOCK_1, `VEND_INIT_STOCK_2,
                                       `VEND_INIT_STOCK_3, `VEND_INIT_STOCK_4};
    int exp_credit = 0;

    vend_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one-cycle pulse, outputs settle two edges later
    task automatic press(input int bit_pos);
        button_sw_oneshot = '0;
        button_sw_oneshot[bit_pos] = 1'b1;
        @(posedge clk);
        #5 button_sw_oneshot = '0;
        @(posedge clk);
        #5;
    endtask

    task automatic insert_coin(input int bit_pos, input int value);
        press(bit_pos);
        if (exp_credit + value <= `VEND_CREDIT_MAX) begin
            exp_credit += value;
        end
        check("credit", credit, exp_credit);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset;
        check("credit", credit, 0);
        check("cursor", cursor, 0);
        check("stock_current", stock_current, exp_stock[0]);
        check("status", status, ST_NONE);
        check("coin_out", coin_out, 0);
        check("refund_busy", refund_busy, 0);
    endtask

    task automatic test_coins_cursor;
        insert_coin(`VEND_BTN_COIN_LARGE, `VEND_COIN_LARGE);
        insert_coin(`VEND_BTN_COIN_MID, `VEND_COIN_MID);
        insert_coin(`VEND_BTN_COIN_SMALL, `VEND_COIN_SMALL);
        check("credit", credit, 16);
        // fourth press hits the bottom
        repeat (4) press(`VEND_BTN_DOWN);
        check("cursor", cursor, 3);
        check("stock_current", stock_current, exp_stock[3]);
        press(`VEND_BTN_UP);
        check("cursor", cursor, 2);
        check("stock_current", stock_current, exp_stock[2]);
    endtask

    task automatic test_select_buy;
        press(`VEND_BTN_SELECT);
        check("selected_item", selected_item, 0);
        check("status", status, ST_SOLD_OUT);
        press(`VEND_BTN_UP);
        press(`VEND_BTN_SELECT);
        check("selected_item", selected_item, 2);
        check("stock_current", stock_current, exp_stock[1]);
        press(`VEND_BTN_BUY);
        exp_credit -= price[1];
        exp_stock[1]--;
        check("credit", credit, exp_credit);
        check("status", status, ST_BOUGHT);
        check("selected_item", selected_item, 0);
        check("stock_current", stock_current, exp_stock[1]);
    endtask

    task automatic test_short_credit;
        repeat (2) press(`VEND_BTN_DOWN);
        press(`VEND_BTN_SELECT);
        check("selected_item", selected_item, 4);
        press(`VEND_BTN_BUY);
        check("status", status, ST_SHORT);
        check("credit", credit, exp_credit);
        check("selected_item", selected_item, 4);
    endtask

    task automatic test_refund;
        int refund;
        int pulses;
        int waited;
        refund = exp_credit;
        pulses = 0;
        waited = 0;
        press(`VEND_BTN_RETURN);
        exp_credit = 0;
        check("credit", credit, exp_credit);
        check("selected_item", selected_item, 0);
        // dispenser picks up the load one cycle behind the core
        while (!refund_busy && waited < 4) begin
            @(posedge clk);
            #5;
            waited++;
        end
        check("refund_busy", refund_busy, 1);
        do begin
            @(posedge clk);
            #5;
            if (coin_out) begin
                pulses++;
            end
        end while (refund_busy);
        check("coin_out pulses", pulses, refund);
    endtask

    task automatic test_admin_restock;
        press(`VEND_BTN_ADD);
        check("stock_current", stock_current, exp_stock[3]);
        press(`VEND_BTN_ADMIN);
        check("status", status, ST_ADMIN_ON);
        check("admin_mode", admin_mode, 1);
        while (exp_stock[3] < `VEND_STOCK_MAX) begin
            press(`VEND_BTN_ADD);
            exp_stock[3]++;
            check("stock_current", stock_current, exp_stock[3]);
        end
        // one past the limit
        press(`VEND_BTN_ADD);
        check("stock_current", stock_current, `VEND_STOCK_MAX);
        press(`VEND_BTN_ADMIN);
        check("status", status, ST_ADMIN_OFF);
        check("admin_mode", admin_mode, 0);
    endtask

    initial begin
        rst = 1'b0;
        button_sw_oneshot = '0;
        repeat (2) @(posedge clk);
        #5 rst = 1'b1;
        test_reset();
        test_coins_cursor();
        test_select_buy();
        test_short_credit();
        test_refund();
        test_admin_restock();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- design/change_dispenser.sv
`timescale 1ns/1ps

`include "vend_defs.svh"

module change_dispenser (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      refund_load,
    input  logic [`VEND_CREDIT_W-1:0] refund_amount,
    output logic                      coin_out,
    output logic                      refund_busy
);

    localparam int tick_w = $clog2(`VEND_PAY_INTERVAL + 1);

    // one spare bit so a second refund can pile on
    logic [`VEND_CREDIT_W:0] remaining;
    logic [tick_w-1:0]       tick_cnt;
    logic [`VEND_CREDIT_W:0] load_add;
    logic                    pay_now;

    assign load_add = refund_load ? {1'b0, refund_amount} : '0;
    assign pay_now  = (remaining != '0) &&
                      (tick_cnt == tick_w'(`VEND_PAY_INTERVAL - 1));

    // busy drops together with the last coin
    assign refund_busy = (remaining != '0);

    ////////////////////////////////////////////////////////////
    // payout timer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            remaining <= '0;
            tick_cnt  <= '0;
            coin_out  <= 1'b0;
        end else begin
            coin_out  <= pay_now;
            remaining <= remaining + load_add - {{`VEND_CREDIT_W{1'b0}}, pay_now};
            if (remaining == '0) begin
                // load cycle counts as the first tick
                tick_cnt <= refund_load ? tick_w'(1) : '0;
            end else if (pay_now) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/key_decoder.sv
`timescale 1ns/1ps

`include "vend_defs.svh"

module key_decoder
    import vend_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`VEND_BTN_W-1:0]    button_sw_oneshot,
    output vend_cmd_e                 cmd,
    output logic [`VEND_CREDIT_W-1:0] coin_value
);

    vend_cmd_e                 cmd_nxt;
    logic [`VEND_CREDIT_W-1:0] coin_nxt;

    // fixed priority, first match wins
    always_comb begin
        cmd_nxt  = CMD_NONE;
        coin_nxt = '0;
        if (button_sw_oneshot[`VEND_BTN_UP]) begin
            cmd_nxt = CMD_UP;
        end else if (button_sw_oneshot[`VEND_BTN_DOWN]) begin
            cmd_nxt = CMD_DOWN;
        end else if (button_sw_oneshot[`VEND_BTN_SELECT]) begin
            cmd_nxt = CMD_SELECT;
        end else if (button_sw_oneshot[`VEND_BTN_COIN_LARGE] ||
                     button_sw_oneshot[`VEND_BTN_COIN_MID] ||
                     button_sw_oneshot[`VEND_BTN_COIN_SMALL]) begin
            cmd_nxt = CMD_COIN;
            // bigger coin wins
            if (button_sw_oneshot[`VEND_BTN_COIN_LARGE]) begin
                coin_nxt = `VEND_CREDIT_W'(`VEND_COIN_LARGE);
            end else if (button_sw_oneshot[`VEND_BTN_COIN_MID]) begin
                coin_nxt = `VEND_CREDIT_W'(`VEND_COIN_MID);
            end else begin
                coin_nxt = `VEND_CREDIT_W'(`VEND_COIN_SMALL);
            end
        end else if (button_sw_oneshot[`VEND_BTN_BUY]) begin
            cmd_nxt = CMD_BUY;
        end else if (button_sw_oneshot[`VEND_BTN_RETURN]) begin
            cmd_nxt = CMD_RETURN;
        end else if (button_sw_oneshot[`VEND_BTN_ADD]) begin
            cmd_nxt = CMD_ADD;
        end else if (button_sw_oneshot[`VEND_BTN_ADMIN]) begin
            cmd_nxt = CMD_ADMIN;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cmd <= CMD_NONE;
        end else begin
            cmd <= cmd_nxt;
        end
    end

    // credit value of the pressed coin
    always_ff @(posedge clk) begin
        coin_value <= coin_nxt;
    end

endmodule

//--- design/vend_core.sv
`timescale 1ns/1ps

`include "vend_defs.svh"

module vend_core
    import vend_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  vend_cmd_e                 cmd,
    input  logic [`VEND_CREDIT_W-1:0] coin_value,
    output logic [`VEND_CREDIT_W-1:0] credit,
    output logic [1:0]                cursor,
    output logic [2:0]                selected_item,
    output logic [`VEND_STOCK_W-1:0]  stock_current,
    output logic                      admin_mode,
    output vend_status_e              status,
    output logic                      refund_load,
    output logic [`VEND_CREDIT_W-1:0] refund_amount
);

    localparam logic [`VEND_CREDIT_W-1:0] price_table [`VEND_NUM_PROD] = '{
        `VEND_PRICE_1,
        `VEND_PRICE_2,
        `VEND_PRICE_3,
        `VEND_PRICE_4
    };

    localparam logic [`VEND_STOCK_W-1:0] init_stock [`VEND_NUM_PROD] = '{
        `VEND_INIT_STOCK_1,
        `VEND_INIT_STOCK_2,
        `VEND_INIT_STOCK_3,
        `VEND_INIT_STOCK_4
    };

    logic [`VEND_STOCK_W-1:0]  stock     [`VEND_NUM_PROD];
    logic [`VEND_STOCK_W-1:0]  stock_nxt [`VEND_NUM_PROD];

    logic [`VEND_CREDIT_W-1:0] credit_nxt;
    logic [1:0]                cursor_nxt;
    logic [2:0]                sel_nxt;
    logic                      admin_nxt;
    vend_status_e              status_nxt;
    logic                      refund_load_nxt;

    // helpers
    logic [`VEND_CREDIT_W:0]   coin_sum;
    logic [1:0]                sel_idx;
    logic [2:0]                cursor_item;
    logic [`VEND_CREDIT_W-1:0] sel_price;

    assign coin_sum    = {1'b0, credit} + {1'b0, coin_value};
    assign sel_idx     = 2'(selected_item - 3'd1);
    assign cursor_item = {1'b0, cursor} + 3'd1;
    assign sel_price   = price_table[sel_idx];

    ////////////////////////////////////////////////////////////
    // command execution
    ////////////////////////////////////////////////////////////

    always_comb begin
        cursor_nxt      = cursor;
        sel_nxt         = selected_item;
        credit_nxt      = credit;
        stock_nxt       = stock;
        admin_nxt       = admin_mode;
        status_nxt      = status;
        refund_load_nxt = 1'b0;

        case (cmd)
            CMD_UP: begin
                if (cursor != 2'd0) begin
                    cursor_nxt = cursor - 2'd1;
                end
            end
            CMD_DOWN: begin
                if (cursor != 2'(`VEND_NUM_PROD - 1)) begin
                    cursor_nxt = cursor + 2'd1;
                end
            end
            CMD_COIN: begin
                // coin is dropped when it would overflow the credit
                if (coin_sum <= `VEND_CREDIT_MAX) begin
                    credit_nxt = coin_sum[`VEND_CREDIT_W-1:0];
                end
            end
            CMD_SELECT: begin
                if (selected_item == cursor_item) begin
                    sel_nxt = 3'd0;
                end else if (stock[cursor] != '0) begin
                    sel_nxt = cursor_item;
                end else begin
                    status_nxt = ST_SOLD_OUT;
                end
            end
            CMD_BUY: begin
                if (selected_item != 3'd0) begin
                    if (credit >= sel_price) begin
                        stock_nxt[sel_idx] = stock[sel_idx] - 1'b1;
                        credit_nxt         = credit - sel_price;
                        sel_nxt            = 3'd0;
                        status_nxt         = ST_BOUGHT;
                    end else begin
                        // selection kept so more coins can follow
                        status_nxt = ST_SHORT;
                    end
                end
            end
            CMD_RETURN: begin
                if (credit != '0) begin
                    refund_load_nxt = 1'b1;
                    credit_nxt      = '0;
                    sel_nxt         = 3'd0;
                end
            end
            CMD_ADD: begin
                if (admin_mode && stock[cursor] < `VEND_STOCK_MAX) begin
                    stock_nxt[cursor] = stock[cursor] + 1'b1;
                end
            end
            CMD_ADMIN: begin
                admin_nxt  = ~admin_mode;
                status_nxt = admin_mode ? ST_ADMIN_OFF : ST_ADMIN_ON;
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor        <= 2'd0;
            selected_item <= 3'd0;
            credit        <= '0;
            stock         <= init_stock;
            admin_mode    <= 1'b0;
            status        <= ST_NONE;
            refund_load   <= 1'b0;
            stock_current <= init_stock[0];
        end else begin
            cursor        <= cursor_nxt;
            selected_item <= sel_nxt;
            credit        <= credit_nxt;
            stock         <= stock_nxt;
            admin_mode    <= admin_nxt;
            status        <= status_nxt;
            refund_load   <= refund_load_nxt;
            // stock of the product under the new cursor
            stock_current <= stock_nxt[cursor_nxt];
        end
    end

    // whole credit handed to the dispenser
    always_ff @(posedge clk) begin
        if (refund_load_nxt) begin
            refund_amount <= credit;
        end
    end

endmodule

//--- design/vend_defs.svh
`ifndef VEND_DEFS_SVH
`define VEND_DEFS_SVH

////////////////////////////////////////////////////////////
// product table
////////////////////////////////////////////////////////////

`define VEND_NUM_PROD       4
`define VEND_STOCK_W        4
`define VEND_STOCK_MAX      9

// prices in 100 won units
`define VEND_PRICE_1        10
`define VEND_PRICE_2        12
`define VEND_PRICE_3        15
`define VEND_PRICE_4        18

`define VEND_INIT_STOCK_1   9
`define VEND_INIT_STOCK_2   1
`define VEND_INIT_STOCK_3   0
`define VEND_INIT_STOCK_4   4

////////////////////////////////////////////////////////////
// credit and payout
////////////////////////////////////////////////////////////

`define VEND_CREDIT_W       8
`define VEND_CREDIT_MAX     255

// 100, 500 and 1000 won coins
`define VEND_COIN_SMALL     1
`define VEND_COIN_MID       5
`define VEND_COIN_LARGE     10

// cycles between refund coins
`define VEND_PAY_INTERVAL   4

////////////////////////////////////////////////////////////
// front panel buttons
////////////////////////////////////////////////////////////

`define VEND_BTN_W          12
`define VEND_BTN_COIN_LARGE 0
`define VEND_BTN_COIN_MID   1
`define VEND_BTN_COIN_SMALL 2
`define VEND_BTN_RETURN     3
`define VEND_BTN_DOWN       4
`define VEND_BTN_ADD        5
`define VEND_BTN_SELECT     7
`define VEND_BTN_BUY        9
`define VEND_BTN_UP         10
`define VEND_BTN_ADMIN      11

`endif

//--- design/vend_pkg.sv
package vend_pkg;

    // one decoded command per cycle from the button stage
    typedef enum logic [3:0] {
        CMD_NONE,
        CMD_UP,
        CMD_DOWN,
        CMD_SELECT,
        CMD_COIN,
        CMD_BUY,
        CMD_RETURN,
        CMD_ADD,
        CMD_ADMIN
    } vend_cmd_e;

    // result of the last command that reports one
    typedef enum logic [2:0] {
        ST_NONE,
        ST_BOUGHT,
        ST_SHORT,      // not enough credit
        ST_SOLD_OUT,
        ST_ADMIN_ON,
        ST_ADMIN_OFF
    } vend_status_e;

endpackage

//--- design/vend_top.sv
`timescale 1ns/1ps

`include "vend_defs.svh"

module vend_top
    import vend_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`VEND_BTN_W-1:0]    button_sw_oneshot,
    output logic [`VEND_CREDIT_W-1:0] credit,
    output logic [1:0]                cursor,
    output logic [2:0]                selected_item,
    output logic [`VEND_STOCK_W-1:0]  stock_current,
    output logic                      admin_mode,
    output vend_status_e              status,
    output logic                      coin_out,
    output logic                      refund_busy
);

    // decoder to core
    vend_cmd_e                 cmd;
    logic [`VEND_CREDIT_W-1:0] coin_value;

    // core to dispenser
    logic                      refund_load;
    logic [`VEND_CREDIT_W-1:0] refund_amount;

    key_decoder u_key_decoder (
        .clk               (clk),
        .rst               (rst),
        .button_sw_oneshot (button_sw_oneshot),
        .cmd               (cmd),
        .coin_value        (coin_value)
    );

    vend_core u_vend_core (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .coin_value    (coin_value),
        .credit        (credit),
        .cursor        (cursor),
        .selected_item (selected_item),
        .stock_current (stock_current),
        .admin_mode    (admin_mode),
        .status        (status),
        .refund_load   (refund_load),
        .refund_amount (refund_amount)
    );

    change_dispenser u_change_dispenser (
        .clk           (clk),
        .rst           (rst),
        .refund_load   (refund_load),
        .refund_amount (refund_amount),
        .coin_out      (coin_out),
        .refund_busy   (refund_busy)
    );

endmodule

//--- vend_top.f
+incdir+design
design/vend_pkg.sv
design/key_decoder.sv
design/vend_core.sv
design/change_dispenser.sv
design/vend_top.sv
bench/vend_tb.sv
